// ==== pmem_cases.txt ====
# op address  wdata    wstrb rdata    resp
# resp 0 is OKAY and 2 is SLVERR, rdata only counts on reads
W 80000010 12345678 f 00000000 0
R 80000010 00000000 0 12345678 0
W 80000014 a5a5a5a5 f 00000000 0
R 80000014 00000000 0 a5a5a5a5 0
R 80000010 00000000 0 12345678 0
# partial strobes merge into 11223344
W 80000020 11223344 f 00000000 0
W 80000020 aabbccdd 5 00000000 0
R 80000020 00000000 0 11bb33dd 0
W 80000020 99887766 8 00000000 0
R 80000020 00000000 0 99bb33dd 0
W 80000023 0000ee00 2 00000000 0
R 80000020 00000000 0 99bbeedd 0
# regions other than 80 get SLVERR
W 80000030 cafef00d f 00000000 0
W 40000030 deadbeef f 00000000 2
R 40000030 00000000 0 00000000 2
R 80000030 00000000 0 cafef00d 0
W 81000030 0badf00d f 00000000 2
R 81000030 00000000 0 00000000 2
W 7f000030 12121212 f 00000000 2
R 80000030 00000000 0 cafef00d 0
# first and last word of the array
W 80000000 00000001 f 00000000 0
W 80000ffc fffffffe f 00000000 0
R 80000000 00000000 0 00000001 0
R 80000ffd 00000000 0 fffffffe 0
# streams of writes then reads
W 80000100 01020304 f 00000000 0
W 80000104 05060708 f 00000000 0
R 80000100 00000000 0 01020304 0
R 80000104 00000000 0 05060708 0
R 80000014 00000000 0 a5a5a5a5 0

// ==== pmem_decode.sv ====
`timescale 1ns/100ps
`include "pmem_params.svh"

module pmem_decode (
    input  logic                            aclk,
    input  logic                            areset_n,

    input  logic                            awvalid,
    output logic                            awready,
    input  logic [`PMEM_ADDR_WIDTH-1:0]     awaddr,
    input  logic [2:0]                      awprot,

    input  logic                            wvalid,
    output logic                            wready,
    input  logic [`PMEM_DATA_WIDTH-1:0]     wdata,
    input  logic [`PMEM_DATA_WIDTH/8-1:0]   wstrb,

    input  logic                            arvalid,
    output logic                            arready,
    input  logic [`PMEM_ADDR_WIDTH-1:0]     araddr,
    input  logic [2:0]                      arprot,

    input  logic                            done,
    pmem_req_if.source                      req_if
);

    logic aw_hs, w_hs, ar_hs;
    logic aw_held, w_held, ar_held, busy;
    logic aw_held_nxt, w_held_nxt, ar_held_nxt, busy_nxt;
    logic go_write, go_read;

    logic [`PMEM_ADDR_WIDTH-1:0]    awaddr_q;
    logic [`PMEM_ADDR_WIDTH-1:0]    araddr_q;
    logic [`PMEM_DATA_WIDTH-1:0]    wdata_q;
    logic [`PMEM_DATA_WIDTH/8-1:0]  wstrb_q;

    pmem_pkg::pmem_addr_u issue_addr;

    // ##########################################################
    // handshakes and issue

    // awprot and arprot are taken but not checked
    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;
    assign ar_hs = arvalid & arready;

    // write wins when both are pending
    assign go_write = !busy & (aw_held | aw_hs) & (w_held | w_hs);
    assign go_read  = !busy & !go_write & (ar_held | ar_hs);

    always_comb begin
        aw_held_nxt = (aw_held | aw_hs) & !go_write;
        w_held_nxt  = (w_held | w_hs) & !go_write;
        ar_held_nxt = (ar_held | ar_hs) & !go_read;
        busy_nxt    = (busy & !done) | go_write | go_read;
    end

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            aw_held    <= 1'b0;
            w_held     <= 1'b0;
            ar_held    <= 1'b0;
            busy       <= 1'b0;
            awready    <= 1'b0;
            wready     <= 1'b0;
            arready    <= 1'b0;
            req_if.req <= 1'b0;
        end else begin
            aw_held    <= aw_held_nxt;
            w_held     <= w_held_nxt;
            ar_held    <= ar_held_nxt;
            busy       <= busy_nxt;
            // a channel is open only while idle and its buffer is empty
            awready    <= !busy_nxt & !aw_held_nxt;
            wready     <= !busy_nxt & !w_held_nxt;
            arready    <= !busy_nxt & !ar_held_nxt;
            req_if.req <= go_write | go_read;
        end
    end

    // ##########################################################
    // channel buffers and request fields

    always_ff @(posedge aclk) begin
        if (aw_hs) begin
            awaddr_q <= awaddr;
        end
        if (w_hs) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (ar_hs) begin
            araddr_q <= araddr;
        end
    end

    // live bus value on the handshake edge, buffer otherwise
    assign issue_addr.raw = go_write ? (aw_hs ? awaddr : awaddr_q)
                                     : (ar_hs ? araddr : araddr_q);

    always_ff @(posedge aclk) begin
        if (go_write | go_read) begin
            req_if.is_write <= go_write;
            req_if.in_range <= (issue_addr.fields.region == `PMEM_BASE_REGION);
            req_if.word_idx <= issue_addr.fields.word_idx[`PMEM_DEPTH_LOG2-1:0];
            req_if.wdata    <= w_hs ? wdata : wdata_q;
            req_if.wstrb    <= w_hs ? wstrb : wstrb_q;
        end
    end

    // new requests only leave an idle decoder
    a_req_from_idle: assert property (@(posedge aclk) disable iff (areset_n)
        req_if.req |-> !$past(busy));

endmodule

// ==== pmem_execute.sv ====
`timescale 1ns/100ps
`include "pmem_params.svh"

module pmem_execute (
    input  logic        aclk,
    input  logic        areset_n,
    pmem_req_if.sink    req_if,
    pmem_rsp_if.source  rsp_if
);

    localparam int unsigned DEPTH  = 1 << `PMEM_DEPTH_LOG2;
    localparam int unsigned STRB_W = `PMEM_DATA_WIDTH / 8;

    logic [`PMEM_DATA_WIDTH-1:0] mem [DEPTH];

    // ##########################################################
    // storage

    // byte lanes follow the strobe
    always_ff @(posedge aclk) begin
        if (req_if.req && req_if.is_write && req_if.in_range) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (req_if.wstrb[i]) begin
                    mem[req_if.word_idx][8*i +: 8] <= req_if.wdata[8*i +: 8];
                end
            end
        end
    end

    // ##########################################################
    // response

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            rsp_if.rsp <= 1'b0;
        end else begin
            rsp_if.rsp <= req_if.req;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_if.req) begin
            rsp_if.is_write <= req_if.is_write;
            rsp_if.resp     <= req_if.in_range ? pmem_pkg::resp_okay
                                               : pmem_pkg::resp_slverr;
            if (!req_if.is_write) begin
                // outside the window reads as zero
                rsp_if.rdata <= req_if.in_range ? mem[req_if.word_idx] : '0;
            end
        end
    end

    a_rsp_after_req: assert property (@(posedge aclk) disable iff (areset_n)
        req_if.req |=> rsp_if.rsp);

    a_rsp_has_req: assert property (@(posedge aclk) disable iff (areset_n)
        rsp_if.rsp |-> $past(req_if.req));

endmodule

// ==== pmem_params.svh ====
`ifndef PMEM_PARAMS_SVH
`define PMEM_PARAMS_SVH

// bus widths
`define PMEM_ADDR_WIDTH 32
`define PMEM_DATA_WIDTH 32

// 1024 words of storage
`define PMEM_DEPTH_LOG2 10

// region field of the memory window, 0x8000_0000 upward
`define PMEM_BASE_REGION 8'h80

`endif

// ==== pmem_pkg.sv ====
`include "pmem_params.svh"

package pmem_pkg;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_t;

    // region, word index and byte offset
    // word index also covers the address bits above the memory depth
    typedef struct packed {
        logic [7:0]                     region;
        logic [`PMEM_ADDR_WIDTH-11:0]   word_idx;
        logic [1:0]                     offset;
    } pmem_addr_fields_t;

    typedef union packed {
        logic [`PMEM_ADDR_WIDTH-1:0]    raw;
        pmem_addr_fields_t              fields;
    } pmem_addr_u;

endpackage

// ==== pmem_req_if.sv ====
`timescale 1ns/100ps
`include "pmem_params.svh"

interface pmem_req_if;

    logic                           req;
    logic                           is_write;
    logic                           in_range;
    logic [`PMEM_DEPTH_LOG2-1:0]    word_idx;
    logic [`PMEM_DATA_WIDTH-1:0]    wdata;
    logic [`PMEM_DATA_WIDTH/8-1:0]  wstrb;

    // decode side
    modport source (
        output req, is_write, in_range, word_idx, wdata, wstrb
    );

    // execute side
    modport sink (
        input req, is_write, in_range, word_idx, wdata, wstrb
    );

endinterface

// ==== pmem_result.sv ====
`timescale 1ns/100ps
`include "pmem_params.svh"

module pmem_result (
    input  logic                            aclk,
    input  logic                            areset_n,
    pmem_rsp_if.sink                        rsp_if,

    output logic                            bvalid,
    input  logic                            bready,
    output logic [1:0]                      bresp,

    output logic                            rvalid,
    input  logic                            rready,
    output logic [`PMEM_DATA_WIDTH-1:0]     rdata,
    output logic [1:0]                      rresp,

    output logic                            done
);

    logic b_hs, r_hs;

    assign b_hs = bvalid & bready;
    assign r_hs = rvalid & rready;

    // frees the decoder
    assign done = b_hs | r_hs;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (rsp_if.rsp && rsp_if.is_write) begin
                bvalid <= 1'b1;
            end else if (b_hs) begin
                bvalid <= 1'b0;
            end
            if (rsp_if.rsp && !rsp_if.is_write) begin
                rvalid <= 1'b1;
            end else if (r_hs) begin
                rvalid <= 1'b0;
            end
        end
    end

    // payload only loads on a new response, so it holds under stall
    always_ff @(posedge aclk) begin
        if (rsp_if.rsp && rsp_if.is_write) begin
            bresp <= rsp_if.resp;
        end
        if (rsp_if.rsp && !rsp_if.is_write) begin
            rdata <= rsp_if.rdata;
            rresp <= rsp_if.resp;
        end
    end

    a_one_channel: assert property (@(posedge aclk) disable iff (areset_n)
        !(bvalid && rvalid));

    a_b_hold: assert property (@(posedge aclk) disable iff (areset_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_r_hold: assert property (@(posedge aclk) disable iff (areset_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// ==== pmem_rsp_if.sv ====
`timescale 1ns/100ps
`include "pmem_params.svh"

interface pmem_rsp_if;

    logic                           rsp;
    logic                           is_write;
    pmem_pkg::resp_t                resp;
    logic [`PMEM_DATA_WIDTH-1:0]    rdata;

    // execute side
    modport source (
        output rsp, is_write, resp, rdata
    );

    // result side
    modport sink (
        input rsp, is_write, resp, rdata
    );

endinterface

// ==== pmem_top.sv ====
`timescale 1ns/100ps
`include "pmem_params.svh"

module pmem_top (
    input  logic                            aclk,
    input  logic                            areset_n,

    input  logic                            awvalid,
    output logic                            awready,
    input  logic [`PMEM_ADDR_WIDTH-1:0]     awaddr,
    input  logic [2:0]                      awprot,

    input  logic                            wvalid,
    output logic                            wready,
    input  logic [`PMEM_DATA_WIDTH-1:0]     wdata,
    input  logic [`PMEM_DATA_WIDTH/8-1:0]   wstrb,

    output logic                            bvalid,
    input  logic                            bready,
    output logic [1:0]                      bresp,

    input  logic                            arvalid,
    output logic                            arready,
    input  logic [`PMEM_ADDR_WIDTH-1:0]     araddr,
    input  logic [2:0]                      arprot,

    output logic                            rvalid,
    input  logic                            rready,
    output logic [`PMEM_DATA_WIDTH-1:0]     rdata,
    output logic [1:0]                      rresp
);

    logic done;

    pmem_req_if req_if_i ();
    pmem_rsp_if rsp_if_i ();

    // ##########################################################
    // decode, execute, result

    pmem_decode decode_i (
        .aclk     (aclk),
        .areset_n (areset_n),
        .awvalid  (awvalid),
        .awready  (awready),
        .awaddr   (awaddr),
        .awprot   (awprot),
        .wvalid   (wvalid),
        .wready   (wready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .arprot   (arprot),
        .done     (done),
        .req_if   (req_if_i.source)
    );

    pmem_execute execute_i (
        .aclk     (aclk),
        .areset_n (areset_n),
        .req_if   (req_if_i.sink),
        .rsp_if   (rsp_if_i.source)
    );

    pmem_result result_i (
        .aclk     (aclk),
        .areset_n (areset_n),
        .rsp_if   (rsp_if_i.sink),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .rdata    (rdata),
        .rresp    (rresp),
        .done     (done)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/bash
# build and run the pmem testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_pmem \
    --Mdir obj_dir -o tb_pmem
./obj_dir/tb_pmem | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== sim.f ====
+incdir+.
pmem_pkg.sv
pmem_req_if.sv
pmem_rsp_if.sv
pmem_decode.sv
pmem_execute.sv
pmem_result.sv
pmem_top.sv
tb_pmem.sv

// ==== tb_pmem.sv ====
`timescale 1ns/100ps
`include "pmem_params.svh"

module tb_pmem;

    logic aclk = 1'b0;
    logic areset_n;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [2:0] awprot, arprot;
    logic [1:0] bresp, rresp;
    logic [`PMEM_ADDR_WIDTH-1:0] awaddr, araddr;
    logic [`PMEM_DATA_WIDTH-1:0] wdata, rdata;
    logic [`PMEM_DATA_WIDTH/8-1:0] wstrb;

    // one entry per line of the cases file
    logic [7:0]                     case_op[$];
    logic [`PMEM_ADDR_WIDTH-1:0]    case_addr[$];
    logic [`PMEM_DATA_WIDTH-1:0]    case_wdata[$];
    logic [`PMEM_DATA_WIDTH/8-1:0]  case_wstrb[$];
    logic [`PMEM_DATA_WIDTH-1:0]    case_rdata[$];
    logic [1:0]                     case_resp[$];

    int errors = 0;
    int n_cases = 0;
    logic loaded = 1'b0;
    logic [31:0] lfsr = 32'h878c9892;

    pmem_top pmem_top_i (.*);

    always #20 aclk = ~aclk;

    // taps 32, 22, 2, 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    task automatic load_cases();
        int fd;
        int n;
        string line;
        logic [7:0] op;
        logic [`PMEM_ADDR_WIDTH-1:0] addr;
        logic [`PMEM_DATA_WIDTH-1:0] wd, rd;
        logic [`PMEM_DATA_WIDTH/8-1:0] strb;
        logic [1:0] resp;
        fd = $fopen("pmem_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open pmem_cases.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%c %h %h %h %h %h", op, addr, wd, strb, rd, resp);
            // comment and blank lines fall short of six fields
            if (n == 6 && (op == "W" || op == "R")) begin
                case_op.push_back(op);
                case_addr.push_back(addr);
                case_wdata.push_back(wd);
                case_wstrb.push_back(strb);
                case_rdata.push_back(rd);
                case_resp.push_back(resp);
            end
        end
        $fclose(fd);
        n_cases = case_op.size();
    endtask

    // ##########################################################
    // one transaction, issue then response

    task automatic run_case(input int i);
        logic is_wr;
        logic aw_need, w_need, ar_need;
        logic aw_first, vld, seen, fin;
        logic [1:0] gap, rsp;
        int aw_at, w_at, cyc, cnt;
        is_wr    = (case_op[i] == "W");
        aw_need  = is_wr;
        w_need   = is_wr;
        ar_need  = !is_wr;
        aw_first = next_bit();
        gap[1]   = next_bit();
        gap[0]   = next_bit();
        aw_at    = aw_first ? 0 : int'(gap);
        w_at     = aw_first ? int'(gap) : 0;
        cyc      = 0;
        while (aw_need || w_need || ar_need) begin
            @(negedge aclk);
            awaddr  = case_addr[i];
            araddr  = case_addr[i];
            wdata   = case_wdata[i];
            wstrb   = case_wstrb[i];
            awvalid = aw_need && (cyc >= aw_at);
            wvalid  = w_need && (cyc >= w_at);
            arvalid = ar_need;
            // readies only change on the rising edge
            aw_need = aw_need && !(awvalid && awready);
            w_need  = w_need && !(wvalid && wready);
            ar_need = ar_need && !(arvalid && arready);
            cyc++;
        end
        cnt  = 0;
        seen = 1'b0;
        fin  = 1'b0;
        while (!fin) begin
            @(negedge aclk);
            awvalid = 1'b0;
            wvalid  = 1'b0;
            arvalid = 1'b0;
            bready  = next_bit();
            rready  = next_bit();
            cnt++;
            vld = is_wr ? bvalid : rvalid;
            rsp = is_wr ? bresp : rresp;
            if (awready || wready || arready) begin
                errors++;
                $display("case %0d: a request channel opened before the response ended", i);
            end
            if (is_wr ? rvalid : bvalid) begin
                errors++;
                $display("case %0d: response arrived on the wrong channel", i);
            end
            if (vld && !seen) begin
                if (cnt != 3) begin
                    errors++;
                    $display("case %0d: valid came %0d cycles after the handshake, not 3", i, cnt);
                end
                seen = 1'b1;
            end else if (!vld && seen) begin
                errors++;
                $display("case %0d: valid dropped before the master was ready", i);
                fin = 1'b1;
            end else if (!vld && cnt > 3) begin
                errors++;
                $display("case %0d: no response to the request", i);
                fin = 1'b1;
            end
            // must hold the expected payload on every stalled cycle
            if (vld && rsp != case_resp[i]) begin
                errors++;
                $display("ERR %s expected %h got %h (case %0d)",
                         is_wr ? "bresp" : "rresp", case_resp[i], rsp, i);
            end
            if (vld && !is_wr && rdata != case_rdata[i]) begin
                errors++;
                $display("ERR rdata expected %h got %h (case %0d)", case_rdata[i], rdata, i);
            end
            fin = fin || (vld && (is_wr ? bready : rready));
        end
        @(negedge aclk);
        bready = 1'b0;
        rready = 1'b0;
        if (bvalid || rvalid) begin
            errors++;
            $display("case %0d: response still valid after its handshake", i);
        end
    endtask

    initial begin
        areset_n = 1'b1;
        awvalid  = 1'b0;
        awaddr   = '0;
        awprot   = 3'd0;
        wvalid   = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = '0;
        arprot   = 3'd0;
        rready   = 1'b0;
        load_cases();
        if (n_cases == 0) begin
            errors++;
            $display("no usable cases in pmem_cases.txt");
        end
        loaded = 1'b1;
        repeat (2) begin
            @(negedge aclk);
            if (bvalid || rvalid) begin
                errors++;
                $display("ERR bvalid,rvalid expected 0,0 got %h,%h in reset", bvalid, rvalid);
            end
        end
        areset_n = 1'b0;
        @(negedge aclk);
        if (bvalid || rvalid || !awready || !wready || !arready) begin
            errors++;
            $display("ERR awready,wready,arready expected 7 got %h, bvalid,rvalid got %h",
                     {awready, wready, arready}, {bvalid, rvalid});
        end
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end
        $display("%0d cases run, %0d errors", n_cases, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // 64 cycles per case plus one slot for reset
    initial begin
        wait (loaded);
        repeat ((n_cases + 1) * 64) @(posedge aclk);
        $display("watchdog ran out after %0d cycles, the run did not finish",
                 (n_cases + 1) * 64);
        $display("Test failures found");
        $finish;
    end

endmodule
